// File: dv/lc4_clock_gen.sv
module lc4_clock_gen (
    output logic gwe,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        gwe = 1'b0;
        forever #5 gwe = ~gwe;
    end

    // power-on reset for two rising edges
    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge gwe);
        #1 o_rst = 1'b0;
    end

endmodule

// File: dv/lc4_tb.sv
`include "lc4_settings.svh"

module lc4_tb
    import lc4_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_DEPTH  = 1 << `LC4_MEM_AW;
    localparam int RETIRE_CNT = 200;
    localparam int WAIT_LIMIT = 20;
    localparam int KIND_ALU   = 0;
    localparam int KIND_MEM   = 1;
    localparam int KIND_BR    = 2;

    logic    gwe;
    logic    por_rst;
    logic    test_rst;
    logic    rst;
    word_t   imem_addr;
    word_t   imem_data;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    logic    dmem_we;
    word_t   dmem_rdata;
    retire_t retire;

    word_t imem [MEM_DEPTH];
    word_t dmem [MEM_DEPTH];

    // ISA model state
    word_t m_dmem [MEM_DEPTH];
    word_t m_regs [`LC4_REG_CNT];
    word_t m_pc;
    nzp_t  m_nzp;

    logic [31:0] lfsr_q;
    int          errors;
    int          tests_run;
    int          tests_failed;

    lc4_clock_gen u_clk (
        .gwe   (gwe),
        .o_rst (por_rst)
    );

    assign rst = por_rst | test_rst;

    lc4_pipeline u_dut (
        .gwe          (gwe),
        .i_rst        (rst),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_we    (dmem_we),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[`LC4_MEM_AW-1:0]];
    assign dmem_rdata = dmem[dmem_addr[`LC4_MEM_AW-1:0]];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr[`LC4_MEM_AW-1:0]] <= dmem_wdata;
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic word_t sext(input word_t v, input int bits);
        word_t ext;
        word_t low;
        ext = 16'hffff << bits;
        low = v & ~ext;
        return v[bits-1] ? (low | ext) : low;
    endfunction

    function automatic word_t gen_insn(input int kind, input int reg_bits);
        word_t    sel;
        word_t    r;
        reg_sel_t rd;
        reg_sel_t rs;
        reg_sel_t rt;
        word_t    imm;
        sel = take_bits(4);
        r   = take_bits(reg_bits);
        rd  = r[2:0];
        r   = take_bits(reg_bits);
        rs  = r[2:0];
        r   = take_bits(reg_bits);
        rt  = r[2:0];
        imm = take_bits(9);
        if (kind != KIND_ALU && sel < 3) begin
            return {4'b0110, rd, rs, imm[5:0]};
        end else if (kind != KIND_ALU && sel < 5) begin
            return {4'b0111, rt, rs, imm[5:0]};
        end else if (kind == KIND_BR && sel < 8) begin
            // short offsets of either sign, an empty mask is a NOP
            return {4'b0000, imm[8:6], {5{imm[3]}}, imm[3:0]};
        end else if (sel >= 13) begin
            return {4'b1001, rd, imm[8:0]};
        end
        sel = take_bits(3);
        case (sel[2:0])
            3'd0:    return {4'b0001, rd, rs, 3'b000, rt};
            3'd1:    return {4'b0001, rd, rs, 3'b010, rt};
            3'd2:    return {4'b0001, rd, rs, 1'b1, imm[4:0]};
            3'd3:    return {4'b0101, rd, rs, 3'b000, rt};
            3'd4:    return {4'b0101, rd, rs, 3'b001, rt};
            3'd5:    return {4'b0101, rd, rs, 3'b010, rt};
            3'd6:    return {4'b0101, rd, rs, 3'b011, rt};
            default: return {4'b0101, rd, rs, 1'b1, imm[4:0]};
        endcase
    endfunction

    task automatic check_eq(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("error: %s actual %h expected %h", name, actual, expected);
        end
    endtask

    // executes one instruction and returns its retire record
    task automatic model_step(output retire_t exp);
        word_t    insn;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    addr;
        word_t    next_pc;
        reg_sel_t rd;
        logic     wr;
        insn    = imem[m_pc[`LC4_MEM_AW-1:0]];
        rd      = insn[11:9];
        a       = m_regs[insn[8:6]];
        b       = insn[5] ? sext(insn, 5) : m_regs[insn[2:0]];
        res     = '0;
        wr      = 1'b0;
        next_pc = m_pc + 16'd1;
        exp       = '0;
        exp.valid = 1'b1;
        exp.pc    = m_pc;
        exp.insn  = insn;
        case (insn[15:12])
            4'b0000: begin
                if ((insn[11:9] & m_nzp) != 3'b000) begin
                    next_pc = m_pc + 16'd1 + sext(insn, 9);
                end
            end
            4'b0001: begin
                wr  = 1'b1;
                res = (!insn[5] && insn[4:3] == 2'b10) ? a - b : a + b;
            end
            4'b0101: begin
                wr = 1'b1;
                if (insn[5]) begin
                    res = a & b;
                end else begin
                    case (insn[4:3])
                        2'd0:    res = a & b;
                        2'd1:    res = ~a;
                        2'd2:    res = a | b;
                        default: res = a ^ b;
                    endcase
                end
            end
            4'b0110: begin
                wr            = 1'b1;
                addr          = a + sext(insn, 6);
                res           = m_dmem[addr[`LC4_MEM_AW-1:0]];
                exp.dmem_addr = addr;
            end
            4'b0111: begin
                addr           = a + sext(insn, 6);
                exp.dmem_we    = 1'b1;
                exp.dmem_addr  = addr;
                exp.dmem_wdata = m_regs[rd];
                m_dmem[addr[`LC4_MEM_AW-1:0]] = m_regs[rd];
            end
            4'b1001: begin
                wr  = 1'b1;
                res = sext(insn, 9);
            end
            default: ;
        endcase
        if (wr) begin
            m_regs[rd]   = res;
            m_nzp        = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
            exp.rf_we    = 1'b1;
            exp.rf_wsel  = rd;
            exp.rf_wdata = res;
        end
        m_pc = next_pc;
    endtask

    task automatic compare_retire(input retire_t act, input retire_t exp);
        check_eq("o_retire.pc", act.pc, exp.pc);
        check_eq("o_retire.insn", act.insn, exp.insn);
        check_eq("o_retire.rf_we", word_t'(act.rf_we), word_t'(exp.rf_we));
        check_eq("o_retire.rf_wsel", word_t'(act.rf_wsel), word_t'(exp.rf_wsel));
        check_eq("o_retire.rf_wdata", act.rf_wdata, exp.rf_wdata);
        check_eq("o_retire.dmem_we", word_t'(act.dmem_we), word_t'(exp.dmem_we));
        check_eq("o_retire.dmem_addr", act.dmem_addr, exp.dmem_addr);
        check_eq("o_retire.dmem_wdata", act.dmem_wdata, exp.dmem_wdata);
    endtask

    task automatic load_program(input int kind, input int reg_bits);
        word_t v;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i]   = gen_insn(kind, reg_bits);
            v         = take_bits(16);
            dmem[i]  <= v;
            m_dmem[i] = v;
        end
        for (int i = 0; i < `LC4_REG_CNT; i++) begin
            m_regs[i] = '0;
        end
        m_pc  = `LC4_RESET_PC;
        m_nzp = '0;
    endtask

    task automatic apply_reset(input int kind, input int reg_bits);
        @(posedge gwe);
        #1 test_rst = 1'b1;
        // the edge lets a store still in memory finish first
        @(posedge gwe);
        #1;
        load_program(kind, reg_bits);
        check_eq("o_retire.valid in reset", word_t'(retire.valid), 16'h0);
        check_eq("o_dmem_we in reset", word_t'(dmem_we), 16'h0);
        @(posedge gwe);
        #1 test_rst = 1'b0;
        for (int c = 0; c < 4; c++) begin
            if (c > 0) begin
                @(posedge gwe);
                #1;
            end
            check_eq("o_retire.valid after reset", word_t'(retire.valid), 16'h0);
            // a store fetched first reaches memory in the fourth cycle
            if (c < 3) begin
                check_eq("o_dmem_we after reset", word_t'(dmem_we), 16'h0);
            end
        end
    endtask

    task automatic run_test(input string name, input int kind, input int reg_bits);
        retire_t exp;
        int      errs_before;
        int      waited;
        int      total;
        int      n;
        logic    aborted;
        errs_before = errors;
        aborted     = 1'b0;
        total       = 0;
        n           = 0;
        apply_reset(kind, reg_bits);
        while (n < RETIRE_CNT && !aborted) begin
            waited = 0;
            do begin
                @(posedge gwe);
                #1;
                waited++;
                total++;
            end while (!retire.valid && waited < WAIT_LIMIT);
            if (!retire.valid) begin
                $display("%s: core stopped retiring after %0d instructions", name, n);
                errors++;
                aborted = 1'b1;
            end else begin
                model_step(exp);
                if (n == 0) begin
                    check_eq("first o_retire.pc", retire.pc, `LC4_RESET_PC);
                end
                compare_retire(retire, exp);
                // later records are meaningless once the streams part
                aborted = (errors != errs_before);
                n++;
            end
        end
        if (!aborted) begin
            if (total > 5 * RETIRE_CNT) begin
                $display("%s: %0d instructions took %0d cycles, over five per instruction",
                         name, RETIRE_CNT, total);
                errors++;
            end
            for (int i = 0; i < MEM_DEPTH && errors == errs_before; i++) begin
                check_eq($sformatf("dmem[%0d]", i), dmem[i], m_dmem[i]);
            end
        end
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: pass, %0d cycles", name, total);
        end
    endtask

    initial begin
        test_rst     = 1'b1;
        lfsr_q       = 32'h8b12;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        run_test("alu_const", KIND_ALU, 2);
        run_test("load_store", KIND_MEM, 3);
        run_test("branch", KIND_BR, 3);
        run_test("dense_mix", KIND_BR, 1);
        $display("tests run %0d, failing %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: include/lc4_settings.svh
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

// data and instruction word width
`define LC4_WORD_W 16

// architectural registers r0..r7
`define LC4_REG_CNT 8

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// address bits decoded by the testbench memories
`define LC4_MEM_AW 8

`endif

// File: project.f
+incdir+include
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_pipeline.sv
dv/lc4_clock_gen.sv
dv/lc4_tb.sv

// File: verilog/lc4_alu.sv
module lc4_alu
    import lc4_pkg::*;
(
    input  dec_t  i_dec,
    input  word_t i_pc,
    input  word_t i_rs,
    input  word_t i_rt,
    output word_t o_result,
    output word_t o_target
);

    word_t opnd_b;

    assign opnd_b = i_dec.use_imm ? i_dec.imm : i_rt;

    // loads and stores decode as ALU_ADD with the offset, giving rs + imm
    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:      o_result = i_rs + opnd_b;
            ALU_SUB:      o_result = i_rs - opnd_b;
            ALU_AND:      o_result = i_rs & opnd_b;
            ALU_NOT:      o_result = ~i_rs;
            ALU_OR:       o_result = i_rs | opnd_b;
            ALU_XOR:      o_result = i_rs ^ opnd_b;
            ALU_PASS_IMM: o_result = i_dec.imm;
            default:      o_result = i_rs + opnd_b;
        endcase
    end

    // pc-relative branch target
    assign o_target = i_pc + 16'd1 + i_dec.imm;

endmodule

// File: verilog/lc4_decoder.sv
module lc4_decoder
    import lc4_pkg::*;
(
    input  word_t i_insn,
    output dec_t  o_dec
);

    word_t sext5;
    word_t sext6;
    word_t sext9;
    dec_t  dec_c;

    assign sext5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign sext6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign sext9 = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        dec_c    = '0;
        dec_c.rs = i_insn[8:6];
        dec_c.rt = i_insn[2:0];
        dec_c.rd = i_insn[11:9];
        case (i_insn[15:12])
            4'b0000: begin
                // BR with an empty nzp mask is the NOP
                if (i_insn[11:9] != 3'b000) begin
                    dec_c.op  = OP_BR;
                    dec_c.imm = sext9;
                end
            end
            4'b0001: begin
                if (i_insn[5]) begin
                    dec_c.op      = OP_ALU;
                    dec_c.use_imm = 1'b1;
                    dec_c.imm     = sext5;
                end else if (i_insn[5:3] == 3'b000) begin
                    dec_c.op = OP_ALU;
                end else if (i_insn[5:3] == 3'b010) begin
                    dec_c.op     = OP_ALU;
                    dec_c.alu_op = ALU_SUB;
                end
            end
            4'b0101: begin
                dec_c.op = OP_ALU;
                if (i_insn[5]) begin
                    dec_c.alu_op  = ALU_AND;
                    dec_c.use_imm = 1'b1;
                    dec_c.imm     = sext5;
                end else begin
                    case (i_insn[5:3])
                        3'b000:  dec_c.alu_op = ALU_AND;
                        3'b001:  dec_c.alu_op = ALU_NOT;
                        3'b010:  dec_c.alu_op = ALU_OR;
                        3'b011:  dec_c.alu_op = ALU_XOR;
                        default: dec_c.op = OP_NOP;
                    endcase
                end
            end
            4'b0110: begin
                dec_c.op      = OP_LDR;
                dec_c.use_imm = 1'b1;
                dec_c.imm     = sext6;
            end
            4'b0111: begin
                // store data register sits in the rd field
                dec_c.op      = OP_STR;
                dec_c.rt      = i_insn[11:9];
                dec_c.use_imm = 1'b1;
                dec_c.imm     = sext6;
            end
            4'b1001: begin
                dec_c.op      = OP_CONST;
                dec_c.alu_op  = ALU_PASS_IMM;
                dec_c.use_imm = 1'b1;
                dec_c.imm     = sext9;
            end
            default: dec_c.op = OP_NOP;
        endcase

        dec_c.rd_we  = dec_c.op inside {OP_ALU, OP_CONST, OP_LDR};
        dec_c.nzp_we = dec_c.op inside {OP_ALU, OP_CONST, OP_LDR};
        dec_c.rs_re  = dec_c.op inside {OP_ALU, OP_LDR, OP_STR};
        dec_c.rt_re  = (dec_c.op == OP_STR) ||
                       ((dec_c.op == OP_ALU) && !dec_c.use_imm && (dec_c.alu_op != ALU_NOT));
    end

    assign o_dec = dec_c;

endmodule

// File: verilog/lc4_hazard_unit.sv
module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  dec_t     i_d_dec,
    input  stage_t   i_x,
    input  stage_t   i_m,
    input  stage_t   i_w,
    output logic     o_stall,
    output fwd_sel_t o_fwd_rs,
    output fwd_sel_t o_fwd_rt,
    output logic     o_fwd_store
);

    logic x_is_load;
    logic load_use;
    logic load_branch;
    logic m_writes;
    logic w_writes;

    // younger producer in M wins over W
    function automatic fwd_sel_t pick_src(input logic re, input reg_sel_t sel,
                                          input logic m_wr, input reg_sel_t m_rd,
                                          input logic w_wr, input reg_sel_t w_rd);
        if (re && m_wr && (m_rd == sel)) begin
            return FWD_M;
        end else if (re && w_wr && (w_rd == sel)) begin
            return FWD_W;
        end
        return FWD_REG;
    endfunction

    assign x_is_load = i_x.valid && (i_x.dec.op == OP_LDR);

    // store data from a load is caught later by the WM bypass
    assign load_use = x_is_load &&
                      ((i_d_dec.rs_re && (i_d_dec.rs == i_x.dec.rd)) ||
                       (i_d_dec.rt_re && (i_d_dec.op != OP_STR) && (i_d_dec.rt == i_x.dec.rd)));

    // load nzp is only known after memory
    assign load_branch = x_is_load && (i_d_dec.op == OP_BR);

    assign o_stall = load_use || load_branch;

    assign m_writes = i_m.valid && i_m.dec.rd_we;
    assign w_writes = i_w.valid && i_w.dec.rd_we;

    assign o_fwd_rs = pick_src(i_x.dec.rs_re, i_x.dec.rs,
                               m_writes, i_m.dec.rd, w_writes, i_w.dec.rd);
    assign o_fwd_rt = pick_src(i_x.dec.rt_re, i_x.dec.rt,
                               m_writes, i_m.dec.rd, w_writes, i_w.dec.rd);

    assign o_fwd_store = i_m.valid && (i_m.dec.op == OP_STR) && w_writes &&
                         (i_w.dec.rd == i_m.dec.rt);

    // only store data may bypass from a load in M since it still holds the address
    always_comb begin
        a_fwd_no_load_addr: assert final (
            (i_m.dec.op != OP_LDR) ||
            ((o_fwd_rs != FWD_M) &&
             ((o_fwd_rt != FWD_M) || (i_x.dec.op == OP_STR))));
    end

endmodule

// File: verilog/lc4_pipeline.sv
`include "lc4_settings.svh"

module lc4_pipeline
    import lc4_pkg::*;
(
    input  logic    gwe,
    input  logic    i_rst,
    output word_t   o_imem_addr,
    input  word_t   i_imem_data,
    output word_t   o_dmem_addr,
    output word_t   o_dmem_wdata,
    output logic    o_dmem_we,
    input  word_t   i_dmem_rdata,
    output retire_t o_retire
);

    word_t    pc_q;
    stage_t   d_q;
    stage_t   x_q;
    stage_t   m_q;
    stage_t   w_q;
    nzp_t     nzp_q;
    dec_t     d_dec;
    word_t    rf_rs;
    word_t    rf_rt;
    logic     rf_we;
    logic     stall;
    fwd_sel_t fwd_rs;
    fwd_sel_t fwd_rt;
    logic     fwd_store;
    word_t    x_rs;
    word_t    x_rt;
    word_t    alu_result;
    word_t    br_target;
    logic     br_taken;
    logic     m_is_load;
    logic     m_is_store;
    word_t    store_data;

    function automatic nzp_t nzp_of(input word_t value);
        if (value[`LC4_WORD_W-1]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val,
                                        input word_t m_val, input word_t w_val);
        case (sel)
            FWD_M:   return m_val;
            FWD_W:   return w_val;
            default: return reg_val;
        endcase
    endfunction

    // fetch
    assign o_imem_addr = pc_q;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q <= `LC4_RESET_PC;
        end else if (br_taken) begin
            pc_q <= br_target;
        end else if (!stall) begin
            pc_q <= pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst || br_taken) begin
            d_q <= '0;
        end else if (!stall) begin
            d_q       <= '0;
            d_q.valid <= 1'b1;
            d_q.pc    <= pc_q;
            d_q.insn  <= i_imem_data;
        end
    end

    // decode
    lc4_decoder u_decoder (
        .i_insn (d_q.insn),
        .o_dec  (d_dec)
    );

    assign rf_we = w_q.valid && w_q.dec.rd_we;

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (d_dec.rs),
        .i_rt_sel  (d_dec.rt),
        .o_rs_data (rf_rs),
        .o_rt_data (rf_rt),
        .i_we      (rf_we),
        .i_wsel    (w_q.dec.rd),
        .i_wdata   (w_q.result)
    );

    lc4_hazard_unit u_hazard (
        .i_d_dec     (d_dec),
        .i_x         (x_q),
        .i_m         (m_q),
        .i_w         (w_q),
        .o_stall     (stall),
        .o_fwd_rs    (fwd_rs),
        .o_fwd_rt    (fwd_rt),
        .o_fwd_store (fwd_store)
    );

    // a stall or a taken branch sends a bubble into execute
    always_ff @(posedge gwe) begin
        if (i_rst || br_taken || stall) begin
            x_q <= '0;
        end else begin
            x_q.valid   <= d_q.valid;
            x_q.pc      <= d_q.pc;
            x_q.insn    <= d_q.insn;
            x_q.dec     <= d_dec;
            x_q.rs_data <= rf_rs;
            x_q.rt_data <= rf_rt;
            x_q.result  <= '0;
        end
    end

    // execute
    assign x_rs = fwd_value(fwd_rs, x_q.rs_data, m_q.result, w_q.result);
    assign x_rt = fwd_value(fwd_rt, x_q.rt_data, m_q.result, w_q.result);

    lc4_alu u_alu (
        .i_dec    (x_q.dec),
        .i_pc     (x_q.pc),
        .i_rs     (x_rs),
        .i_rt     (x_rt),
        .o_result (alu_result),
        .o_target (br_target)
    );

    assign br_taken = x_q.valid && (x_q.dec.op == OP_BR) &&
                      ((nzp_q & x_q.insn[11:9]) != 3'b000);

    // the instruction in X is younger than a load in M, so its nzp wins
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_q <= '0;
        end else if (x_q.valid && x_q.dec.nzp_we && (x_q.dec.op != OP_LDR)) begin
            nzp_q <= nzp_of(alu_result);
        end else if (m_is_load) begin
            nzp_q <= nzp_of(i_dmem_rdata);
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_q <= '0;
        end else begin
            m_q         <= x_q;
            m_q.rs_data <= x_rs;
            m_q.rt_data <= x_rt;
            m_q.result  <= alu_result;
        end
    end

    // memory
    assign m_is_load  = m_q.valid && (m_q.dec.op == OP_LDR);
    assign m_is_store = m_q.valid && (m_q.dec.op == OP_STR);
    assign store_data = fwd_store ? w_q.result : m_q.rt_data;

    assign o_dmem_addr  = (m_is_load || m_is_store) ? m_q.result : '0;
    assign o_dmem_we    = m_is_store;
    assign o_dmem_wdata = m_is_store ? store_data : '0;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            w_q <= '0;
        end else begin
            w_q         <= m_q;
            w_q.rs_data <= m_q.result;
            w_q.rt_data <= store_data;
            w_q.result  <= m_is_load ? i_dmem_rdata : m_q.result;
        end
    end

    // writeback and retire record
    always_comb begin
        o_retire            = '0;
        o_retire.valid      = w_q.valid;
        o_retire.pc         = w_q.pc;
        o_retire.insn       = w_q.insn;
        o_retire.rf_we      = rf_we;
        o_retire.rf_wsel    = rf_we ? w_q.dec.rd : 3'b000;
        o_retire.rf_wdata   = rf_we ? w_q.result : '0;
        o_retire.dmem_we    = w_q.valid && (w_q.dec.op == OP_STR);
        o_retire.dmem_addr  = (w_q.valid && (w_q.dec.op inside {OP_LDR, OP_STR})) ?
                              w_q.rs_data : '0;
        o_retire.dmem_wdata = o_retire.dmem_we ? w_q.rt_data : '0;
    end

    // a store that sat in D under a taken branch never reaches the bus
    a_dmem_we_src: assert property (@(posedge gwe) disable iff (i_rst)
        o_dmem_we |-> !$past(br_taken, 2));

endmodule

// File: verilog/lc4_pkg.sv
package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [2:0]  nzp_t;

    // instruction classes, OP_NOP must stay zero so a cleared latch is a bubble
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ALU   = 3'd1,
        OP_CONST = 3'd2,
        OP_LDR   = 3'd3,
        OP_STR   = 3'd4,
        OP_BR    = 3'd5
    } op_t;

    typedef enum logic [2:0] {
        ALU_ADD      = 3'd0,
        ALU_SUB      = 3'd1,
        ALU_AND      = 3'd2,
        ALU_NOT      = 3'd3,
        ALU_OR       = 3'd4,
        ALU_XOR      = 3'd5,
        ALU_PASS_IMM = 3'd6
    } alu_op_t;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_M   = 2'd1,
        FWD_W   = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        op_t      op;
        alu_op_t  alu_op;
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     use_imm;
        word_t    imm;
    } dec_t;

    // one pipeline latch, in W rs_data carries the memory address
    // and rt_data the store data
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
        dec_t  dec;
        word_t rs_data;
        word_t rt_data;
        word_t result;
    } stage_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t rf_wsel;
        word_t    rf_wdata;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_wdata;
    } retire_t;

endpackage

// File: verilog/lc4_regfile.sv
module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_rst,
    input  reg_sel_t i_rs_sel,
    input  reg_sel_t i_rt_sel,
    output word_t    o_rs_data,
    output word_t    o_rt_data,
    input  logic     i_we,
    input  reg_sel_t i_wsel,
    input  word_t    i_wdata
);

    word_t regs_q [8];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we) begin
            regs_q[i_wsel] <= i_wdata;
        end
    end

    // writeback in the same cycle is visible to decode
    assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs_q[i_rs_sel];
    assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs_q[i_rt_sel];

endmodule
